/* handle_special_or_trivial.sv */
`timescale 1ns/1ps
`default_nettype none

module handle_special_or_trivial (
  input  ppu_pkg::operation_e op_i,
  input  ppu_pkg::posit_t     p1_i,
  input  ppu_pkg::posit_t     p2_i,
  output ppu_pkg::posit_t     pout_o
);

  logic any_nar;
  logic p1_zero;
  logic p2_zero;
  logic cancels;

  assign any_nar = (p1_i == ppu_pkg::NAR) || (p2_i == ppu_pkg::NAR);
  assign p1_zero = (p1_i == ppu_pkg::ZERO);
  assign p2_zero = (p2_i == ppu_pkg::ZERO);

  // x-x and x+(-x) both collapse to zero
  assign cancels = ((op_i == ppu_pkg::SUB) && (p1_i == p2_i)) ||
                   ((op_i == ppu_pkg::ADD) && (p1_i == ppu_pkg::c2(p2_i)));

  always_comb begin
    if (any_nar) begin
      pout_o = ppu_pkg::NAR;
    end else if ((op_i == ppu_pkg::MUL) && (p1_zero || p2_zero)) begin
      pout_o = ppu_pkg::ZERO;
    end else if (cancels) begin
      pout_o = ppu_pkg::ZERO;
    end else if (p1_zero) begin
      // 0 - p2 gives -p2
      pout_o = (op_i == ppu_pkg::SUB) ? ppu_pkg::c2(p2_i) : p2_i;
    end else if (p2_zero) begin
      pout_o = p1_i;
    end else begin
      // not a special case, value is ignored downstream
      pout_o = ppu_pkg::ZERO;
    end
  end

endmodule

`default_nettype wire

/* input_conditioning.sv */
`timescale 1ns/1ps
`default_nettype none

module input_conditioning (
  input  ppu_pkg::posit_t     p1_i,
  input  ppu_pkg::posit_t     p2_i,
  input  ppu_pkg::operation_e op_i,
  output ppu_pkg::posit_t     p1_o,
  output ppu_pkg::posit_t     p2_o,
  output logic                special_o,
  output ppu_pkg::posit_t     special_value_o
);

  ppu_pkg::posit_t p2_neg;
  logic            op_is_add_or_sub;
  logic            swap;

  // subtraction becomes addition of the negated second operand
  assign p2_neg = (op_i == ppu_pkg::SUB) ? ppu_pkg::c2(p2_i) : p2_i;

  assign op_is_add_or_sub = (op_i == ppu_pkg::ADD) || (op_i == ppu_pkg::SUB);

  // the larger magnitude goes first so the core only ever shifts p2
  assign swap = op_is_add_or_sub && (ppu_pkg::abs(p2_neg) > ppu_pkg::abs(p1_i));

  assign p1_o = swap ? p2_neg : p1_i;
  assign p2_o = swap ? p1_i : p2_neg;

  handle_special_or_trivial u_special (
    .op_i   (op_i),
    .p1_i   (p1_i),
    .p2_i   (p2_i),
    .pout_o (special_value_o)
  );

  // ******************************
  // bypass detection
  // ******************************

  // raw operands are used here, not the conditioned ones
  assign special_o = (p1_i == ppu_pkg::ZERO) ||
                     (p1_i == ppu_pkg::NAR) ||
                     (p2_i == ppu_pkg::ZERO) ||
                     (p2_i == ppu_pkg::NAR) ||
                     ((op_i == ppu_pkg::SUB) && (p1_i == p2_i)) ||
                     ((op_i == ppu_pkg::ADD) && (p1_i == ppu_pkg::c2(p2_i)));

endmodule

`default_nettype wire

/* posit_core.sv */
`timescale 1ns/1ps
`default_nettype none

module posit_core (
  input  ppu_pkg::operation_e                op_i,
  input  logic                               sign1_i,
  input  logic                               sign2_i,
  input  logic signed [ppu_pkg::SCALE_W-1:0] scale1_i,
  input  logic signed [ppu_pkg::SCALE_W-1:0] scale2_i,
  input  logic [ppu_pkg::FRAC_W-1:0]         frac1_i,
  input  logic [ppu_pkg::FRAC_W-1:0]         frac2_i,
  output logic                               sign_o,
  output logic signed [ppu_pkg::SCALE_W-1:0] scale_o,
  output logic [ppu_pkg::CORE_FRAC_W-1:0]    frac_o,
  output logic                               sticky_o
);

  logic [2*ppu_pkg::FRAC_W-1:0]     prod;
  logic [ppu_pkg::SCALE_W-1:0]      shamt;
  logic [ppu_pkg::CORE_FRAC_W-1:0]  a1;
  logic [ppu_pkg::CORE_FRAC_W-1:0]  a2;
  logic [ppu_pkg::CORE_FRAC_W-1:0]  a2_shift;
  logic [ppu_pkg::CORE_FRAC_W-1:0]  mask;
  logic                             lost;

  // ******************************
  // multiply path
  // ******************************

  // both fractions are in [1,2) so the product is in [1,4)
  assign prod = frac1_i * frac2_i;

  // ******************************
  // add path alignment
  // ******************************

  // conditioning put the larger magnitude first, so scale1 >= scale2
  assign shamt = scale1_i - scale2_i;

  // place each fraction below two integer bits of the wide word
  assign a1 = {1'b0, frac1_i, 8'b0};
  assign a2 = {1'b0, frac2_i, 8'b0};
  assign a2_shift = a2 >> shamt;

  // bits pushed out of the word by alignment
  assign mask = (16'd1 << shamt) - 16'd1;
  assign lost = |(a2 & mask);

  always_comb begin
    if (op_i == ppu_pkg::MUL) begin
      sign_o = sign1_i ^ sign2_i;
      scale_o = scale1_i + scale2_i;
      frac_o = {prod, 2'b00};
      sticky_o = 1'b0;
    end else begin
      sign_o = sign1_i;
      scale_o = scale1_i;
      sticky_o = lost;
      if (sign1_i == sign2_i) begin
        frac_o = a1 + a2_shift;
      end else begin
        // with lost bits the true difference lies just below a1 - a2,
        // so take one unit off and let sticky stand for the remainder
        frac_o = a1 - a2_shift - {15'd0, lost};
      end
    end
  end

endmodule

`default_nettype wire

/* posit_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module posit_decode (
  input  ppu_pkg::posit_t                    p_i,
  output logic                               sign_o,
  output logic signed [ppu_pkg::SCALE_W-1:0] scale_o,
  output logic [ppu_pkg::FRAC_W-1:0]         frac_o
);

  logic [ppu_pkg::N-2:0] body;
  logic [ppu_pkg::N-2:0] rest;
  logic                  lead;
  logic                  done;
  logic [3:0]            run;

  assign sign_o = p_i.sm.sign;

  always_comb begin
    body = ppu_pkg::abs(p_i);
    lead = body[ppu_pkg::N-2];

    // length of the regime run of identical leading bits
    run = 4'd0;
    done = 1'b0;
    for (int i = ppu_pkg::N - 2; i >= 0; i--) begin
      if (!done && (body[i] == lead)) begin
        run = run + 4'd1;
      end else begin
        done = 1'b1;
      end
    end

    // drop the run and its terminating bit, what is left is the fraction
    rest = body << (run + 4'd1);

    // k ones mean scale k-1, k zeros mean scale -k (es is zero)
    if (lead) begin
      scale_o = $signed({1'b0, run}) - 5'sd1;
    end else begin
      scale_o = -$signed({1'b0, run});
    end

    frac_o = {1'b1, rest[ppu_pkg::N-2 -: ppu_pkg::FRAC_W-1]};
  end

endmodule

`default_nettype wire

/* posit_encode.sv */
`timescale 1ns/1ps
`default_nettype none

module posit_encode (
  input  logic                               sign_i,
  input  logic signed [ppu_pkg::SCALE_W-1:0] scale_i,
  input  logic [ppu_pkg::CORE_FRAC_W-1:0]    frac_i,
  input  logic                               sticky_i,
  input  logic                               special_i,
  input  ppu_pkg::posit_t                    special_value_i,
  output ppu_pkg::posit_t                    p_o
);

  logic [3:0]            lead_pos;
  logic [15:0]           norm;
  logic signed [6:0]     exp_s;
  logic [4:0]            reg_len;
  logic [23:0]           regime_w;
  logic [23:0]           frac_w;
  logic [23:0]           packed_w;
  logic [ppu_pkg::N-2:0] body;
  logic [ppu_pkg::N-2:0] body_r;
  logic [ppu_pkg::N-2:0] body_f;
  logic                  guard;
  logic                  round_up;
  ppu_pkg::posit_t       mag;

  always_comb begin
    // position of the leading one, the word has its binary point at bit 14
    lead_pos = 4'd0;
    for (int i = 0; i < ppu_pkg::CORE_FRAC_W; i++) begin
      if (frac_i[i]) begin
        lead_pos = 4'(i);
      end
    end
    norm = frac_i << (4'd15 - lead_pos);
    exp_s = scale_i + $signed({3'b000, lead_pos}) - 7'sd14;

    // regime and its terminating bit, left aligned in a long word
    if (exp_s >= 7'sd0) begin
      reg_len = exp_s[4:0] + 5'd2;
      regime_w = ~(24'hff_ffff >> (exp_s[4:0] + 5'd1));
    end else begin
      reg_len = 5'd1 - exp_s[4:0];
      regime_w = 24'h80_0000 >> (5'd0 - exp_s[4:0]);
    end
    frac_w = {norm[14:0], 9'd0} >> reg_len;
    packed_w = regime_w | frac_w;

    // ******************************
    // round to nearest, ties to even
    // ******************************
    body = packed_w[23:17];
    guard = packed_w[16];
    round_up = guard & ((|packed_w[15:0]) | sticky_i | body[0]);
    body_r = body + {6'd0, round_up};

    // out of range never rounds to zero or NaR
    if (exp_s > 7'sd5) begin
      body_f = ppu_pkg::MAXPOS.sm.body;
    end else if (exp_s < -7'sd6) begin
      body_f = ppu_pkg::MINPOS.sm.body;
    end else begin
      body_f = body_r;
    end

    mag = ppu_pkg::posit_t'({1'b0, body_f});
    if (special_i) begin
      p_o = special_value_i;
    end else if (sign_i) begin
      p_o = ppu_pkg::c2(mag);
    end else begin
      p_o = mag;
    end
  end

endmodule

`default_nettype wire

/* ppu_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module ppu_asserts (
  input logic                                       clk_i,
  input logic                                       rst_i,
  input logic                                       op_valid_i,
  input logic                                       in_credit_i,
  input logic                                       out_credit_i,
  input logic                                       out_valid_i,
  input logic [$clog2(ppu_pkg::QUEUE_DEPTH+1)-1:0]  q_count_i
);

  int         fail_count;
  logic [7:0] outstanding;
  logic [7:0] credits_held;

  initial fail_count = 0;

  // operations accepted but not yet handed back as credits, and the output
  // credits rebuilt from the downstream handshake alone
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      outstanding <= '0;
      credits_held <= 8'(ppu_pkg::OUT_CREDITS_RESET);
    end else begin
      outstanding <= outstanding + op_valid_i - in_credit_i;
      credits_held <= credits_held + out_credit_i - out_valid_i;
    end
  end

  a_no_valid_without_credit : assert property (@(posedge clk_i) disable iff (rst_i)
    out_valid_i |-> (credits_held != '0))
    else begin
      $error("out_valid_o high while no output credit is held");
      fail_count++;
    end

  a_credit_follows_op : assert property (@(posedge clk_i) disable iff (rst_i)
    in_credit_i |-> (outstanding != '0))
    else begin
      $error("in_credit_o pulsed with no accepted operation outstanding");
      fail_count++;
    end

  a_queue_bound : assert property (@(posedge clk_i) disable iff (rst_i)
    q_count_i <= ppu_pkg::QUEUE_DEPTH)
    else begin
      $error("result queue count above its depth");
      fail_count++;
    end

endmodule

bind ppu_top ppu_asserts u_asserts (
  .clk_i         (clk_i),
  .rst_i         (rst_i),
  .op_valid_i    (op_valid_i),
  .in_credit_i   (in_credit_o),
  .out_credit_i  (out_credit_i),
  .out_valid_i   (out_valid_o),
  .q_count_i     (q_count)
);

`default_nettype wire

/* ppu_pkg.sv */
`default_nettype none

package ppu_pkg;

  // ******************************
  // widths and sizes
  // ******************************

  localparam int N = 8;
  // hidden bit plus six fraction bits
  localparam int FRAC_W = 7;
  localparam int SCALE_W = 5;
  // fixed point word between core and encoder, two integer bits
  localparam int CORE_FRAC_W = 16;

  localparam int QUEUE_DEPTH = 4;
  localparam int CREDIT_W = 4;
  localparam logic [CREDIT_W-1:0] OUT_CREDITS_RESET = 4'd2;

  typedef enum logic [1:0] {
    ADD = 2'd0,
    SUB = 2'd1,
    MUL = 2'd2
  } operation_e;

  // a posit seen either as raw bits or as sign and body
  typedef union packed {
    logic [N-1:0] bits;
    struct packed {
      logic         sign;
      logic [N-2:0] body;
    } sm;
  } posit_t;

  // ******************************
  // posit constants
  // ******************************

  localparam posit_t ZERO = posit_t'(8'h00);
  localparam posit_t NAR = posit_t'(8'h80);
  localparam posit_t MAXPOS = posit_t'(8'h7f);
  localparam posit_t MINPOS = posit_t'(8'h01);

  // negation of a posit is the two's complement of its bits
  function automatic posit_t c2(input posit_t p);
    logic [N-1:0] neg;
    neg = ~p.bits + 1'b1;
    return posit_t'(neg);
  endfunction

  // magnitude as a body, usable for ordering since posits are monotone
  function automatic logic [N-2:0] abs(input posit_t p);
    posit_t neg;
    neg = c2(p);
    return p.sm.sign ? neg.sm.body : p.sm.body;
  endfunction

endpackage

`default_nettype wire

/* ppu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module ppu_tb;

  localparam int CLK_PERIOD = 40;
  localparam int TOTAL_OPS = 6 + 10 + 40 + 40;

  logic                clk_i;
  logic                rst_i;
  logic                op_valid;
  ppu_pkg::operation_e op;
  ppu_pkg::posit_t     p1;
  ppu_pkg::posit_t     p2;
  logic                out_credit;
  logic                in_credit_o;
  logic                out_valid_o;
  ppu_pkg::posit_t     result_o;

  logic [15:0] lfsr;
  logic [15:0] credit_lfsr;
  logic [7:0]  exp_q [$];
  string       name_q [$];
  int          in_credits;
  int          out_credits_held;
  int          results_seen;
  logic        returns_on;

  ppu_top dut (
    .clk_i(clk_i), .rst_i(rst_i), .op_valid_i(op_valid), .op_i(op), .p1_i(p1), .p2_i(p2),
    .in_credit_o(in_credit_o), .out_credit_i(out_credit), .out_valid_o(out_valid_o),
    .result_o(result_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // ******************************
  // reference model
  // ******************************

  // exact value of a posit in units of 2^-24
  function automatic longint posit_value(input logic [7:0] p);
    logic [7:0] mag;
    logic       lead;
    int         run;
    int         k;
    int         fb;
    longint     mant;
    if (p == 8'h00) return 0;
    mag = p[7] ? -p : p;
    lead = mag[6];
    run = 0;
    while (run < 7 && mag[6-run] == lead) run++;
    k = lead ? run - 1 : -run;
    // bits left after the regime run and its terminator
    fb = (run >= 6) ? 0 : 6 - run;
    mant = (longint'(1) << fb) + (mag & ((8'd1 << fb) - 8'd1));
    mant = mant << (24 + k - fb);
    return p[7] ? -mant : mant;
  endfunction

  // nearest posit, ties to the even pattern, never zero or NaR
  function automatic logic [7:0] round_posit(input longint v);
    longint     mag;
    longint     lo;
    longint     hi;
    logic [7:0] pick;
    mag = (v < 0) ? -v : v;
    pick = ppu_pkg::MINPOS.bits;
    if (mag >= posit_value(ppu_pkg::MAXPOS.bits)) begin
      pick = ppu_pkg::MAXPOS.bits;
    end else if (mag > posit_value(ppu_pkg::MINPOS.bits)) begin
      for (int b = 1; b < 127; b++) begin
        lo = posit_value(8'(b));
        hi = posit_value(8'(b + 1));
        if (mag >= lo && mag < hi) begin
          if (2 * mag < lo + hi) pick = 8'(b);
          else if (2 * mag > lo + hi) pick = 8'(b + 1);
          else pick = b[0] ? 8'(b + 1) : 8'(b);
        end
      end
    end
    return (v < 0) ? -pick : pick;
  endfunction

  function automatic logic [7:0] expected_result(input ppu_pkg::operation_e o,
                                                 input logic [7:0] a, input logic [7:0] b);
    longint r;
    if (a == ppu_pkg::NAR.bits || b == ppu_pkg::NAR.bits) return ppu_pkg::NAR.bits;
    case (o)
      ppu_pkg::ADD: r = posit_value(a) + posit_value(b);
      ppu_pkg::SUB: r = posit_value(a) - posit_value(b);
      default: r = (posit_value(a) * posit_value(b)) >>> 24;
    endcase
    return (r == 0) ? 8'h00 : round_posit(r);
  endfunction

  // ******************************
  // stimulus helpers
  // ******************************

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [7:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = {v[6:0], lfsr[0]};
    end
  endtask

  task automatic check_value(input string name, input int exp, input int got);
    assert (got == exp) else begin
      $display("CHECK FAILED %s expected %0h actual %0h", name, exp, got);
      $display("ERRORS FOUND");
      $fatal(1, "value mismatch");
    end
  endtask

  // called and returning 5 ns after a rising edge
  task automatic send_op(input string name, input ppu_pkg::operation_e o,
                         input logic [7:0] a, input logic [7:0] b);
    while (in_credits == 0) begin
      @(posedge clk_i);
      #5;
    end
    op_valid = 1'b1;
    op = o;
    p1 = ppu_pkg::posit_t'(a);
    p2 = ppu_pkg::posit_t'(b);
    exp_q.push_back(expected_result(o, a, b));
    name_q.push_back(name);
    @(posedge clk_i);
    #5;
    op_valid = 1'b0;
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0) begin
      @(posedge clk_i);
      #5;
    end
  endtask

  task automatic send_random(input string name, input int count, input logic mul);
    logic [7:0] a;
    logic [7:0] b;
    logic [7:0] sel;
    for (int i = 0; i < count; i++) begin
      take_bits(8, a);
      take_bits(8, b);
      take_bits(1, sel);
      if (mul) send_op(name, ppu_pkg::MUL, a, b);
      else send_op(name, sel[0] ? ppu_pkg::SUB : ppu_pkg::ADD, a, b);
    end
  endtask

  // ******************************
  // monitor and scoreboard
  // ******************************

  always @(posedge clk_i) begin
    if (dut.u_asserts.fail_count != 0) begin
      $display("a protocol assertion on ppu_top failed");
      $display("ERRORS FOUND");
      $fatal(1, "protocol violation");
    end else if (!rst_i) begin
      in_credits <= in_credits - int'(op_valid) + int'(in_credit_o);
      out_credits_held <= out_credits_held + int'(out_credit) - int'(out_valid_o);
      if (out_valid_o) begin
        if (exp_q.size() == 0) begin
          $display("a result came out with no operation outstanding");
          $display("ERRORS FOUND");
          $fatal(1, "unexpected result");
        end else begin
          results_seen <= results_seen + 1;
          check_value(name_q.pop_front(), exp_q.pop_front(), result_o.bits);
        end
      end
    end
  end

  // downstream hands back output credits at LFSR chosen cycles
  initial begin
    forever begin
      @(posedge clk_i);
      #5;
      credit_lfsr = lfsr_next(credit_lfsr);
      out_credit = returns_on && (out_credits_held < 4) && credit_lfsr[0];
    end
  end

  initial begin
    #(TOTAL_OPS * 20 * CLK_PERIOD);
    $display("timeout: the results did not all arrive in time");
    $display("ERRORS FOUND");
    $fatal(1, "watchdog expired");
  end

  initial begin
    rst_i = 1'b1;
    op_valid = 1'b0;
    op = ppu_pkg::ADD;
    p1 = ppu_pkg::ZERO;
    p2 = ppu_pkg::ZERO;
    out_credit = 1'b0;
    returns_on = 1'b0;
    lfsr = 16'd29;
    credit_lfsr = 16'd29;
    in_credits = ppu_pkg::QUEUE_DEPTH;
    out_credits_held = int'(ppu_pkg::OUT_CREDITS_RESET);
    results_seen = 0;
    repeat (2) @(posedge clk_i);
    #5;
    rst_i = 1'b0;
    check_value("after_reset", 0, out_valid_o);
    check_value("after_reset", 0, in_credit_o);

    // only the reset credits are spent until downstream returns more
    send_random("credit_protocol", 6, 1'b0);
    repeat (5) @(posedge clk_i);
    #5;
    check_value("credit_protocol", int'(ppu_pkg::OUT_CREDITS_RESET), results_seen);
    check_value("credit_protocol", 4, exp_q.size());
    returns_on = 1'b1;
    wait_drained();

    send_op("special_cases", ppu_pkg::ADD, 8'h00, 8'h40);
    send_op("special_cases", ppu_pkg::SUB, 8'h00, 8'h40);
    send_op("special_cases", ppu_pkg::MUL, 8'h40, 8'h00);
    send_op("special_cases", ppu_pkg::ADD, 8'h80, 8'h40);
    send_op("special_cases", ppu_pkg::MUL, 8'h00, 8'h80);
    send_op("special_cases", ppu_pkg::SUB, 8'h33, 8'h33);
    send_op("special_cases", ppu_pkg::ADD, 8'h33, 8'hcd);
    send_op("special_cases", ppu_pkg::SUB, 8'h50, 8'h00);
    send_op("special_cases", ppu_pkg::SUB, 8'h90, 8'h90);
    send_op("special_cases", ppu_pkg::ADD, 8'h00, 8'h00);

    send_random("add_sub_random", 40, 1'b0);
    send_op("mul_random", ppu_pkg::MUL, 8'h7f, 8'h7f);
    send_op("mul_random", ppu_pkg::MUL, 8'h01, 8'h01);
    send_random("mul_random", 38, 1'b1);
    wait_drained();
    repeat (2) @(posedge clk_i);
    #5;
    check_value("after_reset", ppu_pkg::QUEUE_DEPTH, in_credits);

    if (dut.u_asserts.fail_count != 0) begin
      $display("ERRORS FOUND");
      $fatal(1, "protocol violation");
    end else begin
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule

`default_nettype wire

/* ppu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ppu_top (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                op_valid_i,
  input  ppu_pkg::operation_e op_i,
  input  ppu_pkg::posit_t     p1_i,
  input  ppu_pkg::posit_t     p2_i,
  output logic                in_credit_o,
  input  logic                out_credit_i,
  output logic                out_valid_o,
  output ppu_pkg::posit_t     result_o
);

  ppu_pkg::posit_t p1_c, p2_c, special_value_c;
  logic special_c, sign1_d, sign2_d, sign_c, sticky_c;
  logic signed [ppu_pkg::SCALE_W-1:0] scale1_d, scale2_d, scale_c;
  logic [ppu_pkg::FRAC_W-1:0] frac1_d, frac2_d;
  logic [ppu_pkg::CORE_FRAC_W-1:0] frac_c;
  ppu_pkg::posit_t result_e;

  // stage registers, valid bits are the only control here
  logic s1_valid, s2_valid, s3_valid;
  ppu_pkg::operation_e s1_op;
  logic s1_sign1, s1_sign2, s1_special, s2_sign, s2_sticky, s2_special;
  logic signed [ppu_pkg::SCALE_W-1:0] s1_scale1, s1_scale2, s2_scale;
  logic [ppu_pkg::FRAC_W-1:0] s1_frac1, s1_frac2;
  logic [ppu_pkg::CORE_FRAC_W-1:0] s2_frac;
  ppu_pkg::posit_t s1_special_value, s2_special_value, s3_result;

  ppu_pkg::posit_t q_mem [ppu_pkg::QUEUE_DEPTH];
  logic [$clog2(ppu_pkg::QUEUE_DEPTH)-1:0] wr_ptr, rd_ptr;
  logic [$clog2(ppu_pkg::QUEUE_DEPTH+1)-1:0] q_count;
  logic [ppu_pkg::CREDIT_W-1:0] out_credits;
  logic pop;

  input_conditioning u_cond (
    .p1_i(p1_i), .p2_i(p2_i), .op_i(op_i), .p1_o(p1_c), .p2_o(p2_c),
    .special_o(special_c), .special_value_o(special_value_c)
  );

  posit_decode u_dec1 (.p_i(p1_c), .sign_o(sign1_d), .scale_o(scale1_d), .frac_o(frac1_d));
  posit_decode u_dec2 (.p_i(p2_c), .sign_o(sign2_d), .scale_o(scale2_d), .frac_o(frac2_d));

  posit_core u_core (
    .op_i(s1_op), .sign1_i(s1_sign1), .sign2_i(s1_sign2),
    .scale1_i(s1_scale1), .scale2_i(s1_scale2), .frac1_i(s1_frac1), .frac2_i(s1_frac2),
    .sign_o(sign_c), .scale_o(scale_c), .frac_o(frac_c), .sticky_o(sticky_c)
  );

  posit_encode u_enc (
    .sign_i(s2_sign), .scale_i(s2_scale), .frac_i(s2_frac), .sticky_i(s2_sticky),
    .special_i(s2_special), .special_value_i(s2_special_value), .p_o(result_e)
  );

  // ******************************
  // pipeline
  // ******************************

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
      s3_valid <= 1'b0;
    end else begin
      s1_valid <= op_valid_i;
      s2_valid <= s1_valid;
      s3_valid <= s2_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    s1_op <= op_i;
    s1_sign1 <= sign1_d;
    s1_sign2 <= sign2_d;
    s1_scale1 <= scale1_d;
    s1_scale2 <= scale2_d;
    s1_frac1 <= frac1_d;
    s1_frac2 <= frac2_d;
    s1_special <= special_c;
    s1_special_value <= special_value_c;
    s2_sign <= sign_c;
    s2_scale <= scale_c;
    s2_frac <= frac_c;
    s2_sticky <= sticky_c;
    s2_special <= s1_special;
    s2_special_value <= s1_special_value;
    s3_result <= result_e;
  end

  // ******************************
  // result queue and credits
  // ******************************

  // upstream credits guarantee the queue never overflows
  assign out_valid_o = (q_count != '0) && (out_credits != '0);
  assign pop = out_valid_o;
  assign result_o = q_mem[rd_ptr];
  // a freed entry is handed back to upstream in the same cycle
  assign in_credit_o = pop;

  always_ff @(posedge clk_i) begin
    if (s3_valid) q_mem[wr_ptr] <= s3_result;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      q_count <= '0;
      out_credits <= ppu_pkg::OUT_CREDITS_RESET;
    end else begin
      if (s3_valid) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      case ({s3_valid, pop})
        2'b10: q_count <= q_count + 1'b1;
        2'b01: q_count <= q_count - 1'b1;
        default: q_count <= q_count;
      endcase
      case ({out_credit_i, pop})
        2'b10: out_credits <= out_credits + 1'b1;
        2'b01: out_credits <= out_credits - 1'b1;
        default: out_credits <= out_credits;
      endcase
    end
  end

endmodule

`default_nettype wire

/* sim.f */
ppu_pkg.sv
handle_special_or_trivial.sv
input_conditioning.sv
posit_decode.sv
posit_core.sv
posit_encode.sv
ppu_top.sv
ppu_asserts.sv
ppu_tb.sv
